// ==== source/dct_pkg.sv ====
// widths assume signed 11-bit integer samples and 7-bit unsigned 1.6 cosine constants
package dct_pkg;

    // transform size and widths
    localparam int sample_w = 11;
    localparam int coef_w   = 12;
    localparam int n_points = 16;
    localparam int n_pairs  = n_points / 2;

    // growth of one bit per add rank
    localparam int fold_w = sample_w + 1;
    localparam int diff_w = fold_w + 1;
    localparam int even_w = diff_w + 1;

    // fixed pipeline latency in cycles
    localparam int pipe_depth = 3;

    // dc scaling, arithmetic right shift chosen by block_flag
    localparam int dc_shift_block = 3;
    localparam int dc_shift_plain = 1;

    // cosine constants in 1.6 format, unsigned
    localparam int cos_w = 7;
    typedef logic [cos_w-1:0] cos_t;

    localparam cos_t c2  = 7'd22;
    localparam cos_t c4  = 7'd21;
    localparam cos_t c6  = 7'd19;
    localparam cos_t c10 = 7'd13;
    localparam cos_t c12 = 7'd9;
    localparam cos_t c14 = 7'd4;

    // input side, entry 0 holds x0
    typedef logic signed [sample_w-1:0] sample_t;
    typedef sample_t [n_points-1:0] sample_vec_t;

    // stage 1 result, entry n is x[n] + x[15-n]
    typedef logic signed [fold_w-1:0] fold_sum_t;
    typedef struct packed {
        fold_sum_t [n_pairs-1:0] pair_sum;
        logic                    block_flag;
    } fold_t;

    // stage 2 result
    typedef logic signed [diff_w-1:0] diff_t;
    typedef logic signed [even_w-1:0] even_sum_t;
    typedef struct packed {
        // second rank, e1 = a0+a3, e2 = a1+a2, e3 = a0-a3, e4 = a1-a2
        even_sum_t e1;
        even_sum_t e2;
        even_sum_t e3;
        even_sum_t e4;
        // first rank differences, dn = s[n] - s[7-n]
        diff_t     d0;
        diff_t     d1;
        diff_t     d2;
        diff_t     d3;
        logic      block_flag;
    } even_t;

    // output side, order X0 X2 X4 X6 X8 X10 X12 X14
    typedef logic signed [coef_w-1:0] coef_t;
    typedef coef_t [n_pairs-1:0] even_coef_vec_t;

endpackage

// ==== source/dct_fold_stage.sv ====
// registered fold of mirrored samples; loads every cycle, no handshake, sums cannot overflow
`timescale 1ns/1ps

module dct_fold_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  dct_pkg::sample_vec_t x_in,
    input  logic                block_flag,
    output dct_pkg::fold_t      fold
);

    import dct_pkg::*;

    // next value of the stage register
    fold_t fold_d;

    // common first rank of the even path
    // each pair sign-extends to 12 bits before the add
    always_comb begin
        for (int n = 0; n < n_pairs; n++) begin
            fold_d.pair_sum[n] = fold_sum_t'(x_in[n]) + fold_sum_t'(x_in[n_points-1-n]);
        end
        // flag rides along with its own vector
        fold_d.block_flag = block_flag;
    end

    // stage register
    // cleared on reset so the flag starts at zero too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fold <= '0;
        end else begin
            fold <= fold_d;
        end
    end

endmodule

// ==== source/dct_even_butterfly.sv ====
// two butterfly ranks of the even part; 13-bit first rank, 14-bit second rank, no saturation needed
`timescale 1ns/1ps

module dct_even_butterfly (
    input  logic           clk,
    input  logic           rst_n,
    input  dct_pkg::fold_t fold,
    output dct_pkg::even_t even
);

    import dct_pkg::*;

    // first rank sums, a0..a3
    diff_t a0;
    diff_t a1;
    diff_t a2;
    diff_t a3;

    // next value of the stage register
    even_t even_d;

    // first rank, pairs s0/s7, s1/s6, s2/s5, s3/s4
    // operands are signed so they sign-extend to 13 bits
    assign a0 = diff_t'(fold.pair_sum[0]) + diff_t'(fold.pair_sum[7]);
    assign a1 = diff_t'(fold.pair_sum[1]) + diff_t'(fold.pair_sum[6]);
    assign a2 = diff_t'(fold.pair_sum[2]) + diff_t'(fold.pair_sum[5]);
    assign a3 = diff_t'(fold.pair_sum[3]) + diff_t'(fold.pair_sum[4]);

    always_comb begin
        // differences feed the X2/X6/X10/X14 rotations
        even_d.d0 = diff_t'(fold.pair_sum[0]) - diff_t'(fold.pair_sum[7]);
        even_d.d1 = diff_t'(fold.pair_sum[1]) - diff_t'(fold.pair_sum[6]);
        even_d.d2 = diff_t'(fold.pair_sum[2]) - diff_t'(fold.pair_sum[5]);
        even_d.d3 = diff_t'(fold.pair_sum[3]) - diff_t'(fold.pair_sum[4]);
        // second rank, 14 bits
        // e1/e2 go to X0 and X8, e3/e4 to the X4/X12 rotation
        even_d.e1 = even_sum_t'(a0) + even_sum_t'(a3);
        even_d.e2 = even_sum_t'(a1) + even_sum_t'(a2);
        even_d.e3 = even_sum_t'(a0) - even_sum_t'(a3);
        even_d.e4 = even_sum_t'(a1) - even_sum_t'(a2);
        // flag stays aligned with the data
        even_d.block_flag = fold.block_flag;
    end

    // stage register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            even <= '0;
        end else begin
            even <= even_d;
        end
    end

endmodule

// ==== source/dct_coef_stage.sv ====
// even coefficients by shift-and-add; all but X0 wrap on truncation, trunc_lsb must stay below 13
`timescale 1ns/1ps

module dct_coef_stage #(
    parameter int trunc_lsb = 5
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dct_pkg::even_t          even,
    output dct_pkg::even_coef_vec_t x_out
);

    import dct_pkg::*;

    // product and accumulator width, wide enough for four 20-bit products
    localparam int acc_w = 24;
    // dc sum width, one bit over the second rank
    localparam int dc_w = even_w + 1;
    // X8 uses c8 scaled to 16, a plain shift
    localparam int x8_shift = 4;

    // constant multiply built from shifts and adds
    // one shifted copy of x per set bit of the constant
    function automatic logic signed [acc_w-1:0] cmul(
        input logic signed [acc_w-1:0] x,
        input cos_t                    c
    );
        logic signed [acc_w-1:0] acc;
        acc = '0;
        for (int i = 0; i < cos_w; i++) begin
            if (c[i]) begin
                acc = acc + (x <<< i);
            end
        end
        return acc;
    endfunction

    // operands sign-extended to the accumulator width
    logic signed [acc_w-1:0] e1_x, e2_x, e3_x, e4_x;
    logic signed [acc_w-1:0] d0_x, d1_x, d2_x, d3_x;

    // full-precision results before truncation
    logic signed [acc_w-1:0] p_x2, p_x4, p_x6, p_x8, p_x10, p_x12, p_x14;

    // dc path
    logic signed [dc_w-1:0] dc_sum;
    logic signed [dc_w-1:0] dc_scaled;
    logic                   dc_ovf;
    coef_t                  x0_sat;

    // next value of the output register
    even_coef_vec_t coef_d;

    assign e1_x = even.e1;
    assign e2_x = even.e2;
    assign e3_x = even.e3;
    assign e4_x = even.e4;
    assign d0_x = even.d0;
    assign d1_x = even.d1;
    assign d2_x = even.d2;
    assign d3_x = even.d3;

    // X0, shift depends on block_flag
    assign dc_sum    = even.e1 + even.e2;
    assign dc_scaled = even.block_flag ? (dc_sum >>> dc_shift_block)
                                       : (dc_sum >>> dc_shift_plain);
    // overflow when the bits above the 12-bit sign bit disagree with it
    assign dc_ovf = dc_scaled[dc_w-1:coef_w-1] != {(dc_w-coef_w+1){dc_scaled[dc_w-1]}};
    // clamp to +2047 or -2048 by the sign of the wide value
    assign x0_sat = !dc_ovf ? coef_t'(dc_scaled[coef_w-1:0]) :
                    dc_scaled[dc_w-1] ? {1'b1, {(coef_w-1){1'b0}}}
                                      : {1'b0, {(coef_w-1){1'b1}}};

    // X8
    assign p_x8 = (e1_x - e2_x) <<< x8_shift;

    // X4/X12 rotation on e3, e4
    assign p_x4  = cmul(e3_x, c4) + cmul(e4_x, c12);
    assign p_x12 = cmul(e3_x, c12) - cmul(e4_x, c4);

    // X2/X6/X10/X14 rotations on the first-rank differences
    assign p_x10 = (cmul(d0_x, c10) + cmul(d3_x, c6)) - (cmul(d1_x, c2) - cmul(d2_x, c14));
    assign p_x6  = (cmul(d0_x, c6) - cmul(d3_x, c10)) - (cmul(d1_x, c14) + cmul(d2_x, c2));
    assign p_x2  = (cmul(d0_x, c2) + cmul(d3_x, c14)) + (cmul(d1_x, c6) + cmul(d2_x, c10));
    assign p_x14 = (cmul(d0_x, c14) - cmul(d3_x, c2)) + (cmul(d2_x, c6) - cmul(d1_x, c10));

    // keep bits trunc_lsb+11 down to trunc_lsb, wrap on overflow
    always_comb begin
        coef_d[0] = x0_sat;
        coef_d[1] = p_x2[trunc_lsb +: coef_w];
        coef_d[2] = p_x4[trunc_lsb +: coef_w];
        coef_d[3] = p_x6[trunc_lsb +: coef_w];
        coef_d[4] = p_x8[trunc_lsb +: coef_w];
        coef_d[5] = p_x10[trunc_lsb +: coef_w];
        coef_d[6] = p_x12[trunc_lsb +: coef_w];
        coef_d[7] = p_x14[trunc_lsb +: coef_w];
    end

    // output register, last pipeline stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_out <= '0;
        end else begin
            x_out <= coef_d;
        end
    end

endmodule

// ==== source/dct_col_even.sv ====
// even half of a 16-point column DCT; fixed 3-cycle latency, new vector every cycle, no back-pressure
`timescale 1ns/1ps

module dct_col_even #(
    parameter int trunc_lsb = 5
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dct_pkg::sample_vec_t    x_in,
    input  logic                    block_flag,
    output dct_pkg::even_coef_vec_t x_out
);

    import dct_pkg::*;

    // stage 1 to stage 2
    fold_t fold;
    // stage 2 to stage 3
    even_t even;

    // fold mirrored pairs
    dct_fold_stage dct_fold_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .x_in       (x_in),
        .block_flag (block_flag),
        .fold       (fold)
    );

    // butterfly ranks
    dct_even_butterfly dct_even_butterfly_i (
        .clk   (clk),
        .rst_n (rst_n),
        .fold  (fold),
        .even  (even)
    );

    // coefficients, truncation point set here
    dct_coef_stage #(
        .trunc_lsb (trunc_lsb)
    ) dct_coef_stage_i (
        .clk   (clk),
        .rst_n (rst_n),
        .even  (even),
        .x_out (x_out)
    );

endmodule

// ==== dv/dct_col_even_assert.sv ====
// checks x_out against a model of the inputs held pipe_depth edges earlier; assumes one vector per cycle
`timescale 1ns/1ps

module dct_col_even_assert #(
    parameter int trunc_lsb = 5
) (
    input logic                    clk,
    input logic                    rst_n,
    input dct_pkg::sample_vec_t    x_in,
    input logic                    block_flag,
    input dct_pkg::even_coef_vec_t x_out
);

    import dct_pkg::*;

    // read by the testbench through the bound instance
    int unsigned fail_count;

    // input history, entry pipe_depth-1 lines up with x_out
    sample_vec_t           hist_x [pipe_depth];
    logic [pipe_depth-1:0] hist_f;
    logic [pipe_depth-1:0] hist_v;

    logic           exp_valid;
    even_coef_vec_t exp_coef;

    // keep product bits trunc_lsb+11 down to trunc_lsb, wrapping
    function automatic coef_t trunc_coef(input int p);
        return coef_t'(p >>> trunc_lsb);
    endfunction

    // even coefficients straight from the transform rules
    function automatic even_coef_vec_t even_model(input sample_vec_t x, input logic flag);
        int s [8];
        int a [4];
        int d [4];
        int e1, e2, e3, e4, dc;
        int k2, k4, k6, k10, k12, k14;
        even_coef_vec_t r;
        k2 = int'(c2);
        k4 = int'(c4);
        k6 = int'(c6);
        k10 = int'(c10);
        k12 = int'(c12);
        k14 = int'(c14);
        // mirrored pair sums
        for (int n = 0; n < 8; n++) begin
            s[n] = int'(sample_t'(x[n])) + int'(sample_t'(x[15-n]));
        end
        for (int i = 0; i < 4; i++) begin
            a[i] = s[i] + s[7-i];
            d[i] = s[i] - s[7-i];
        end
        e1 = a[0] + a[3];
        e2 = a[1] + a[2];
        e3 = a[0] - a[3];
        e4 = a[1] - a[2];
        // dc with flag-chosen scaling, then clamp
        dc = flag ? ((e1 + e2) >>> dc_shift_block) : ((e1 + e2) >>> dc_shift_plain);
        if (dc > 2047) begin
            dc = 2047;
        end else if (dc < -2048) begin
            dc = -2048;
        end
        r[0] = coef_t'(dc);
        r[1] = trunc_coef(k2 * d[0] + k14 * d[3] + k6 * d[1] + k10 * d[2]);
        r[2] = trunc_coef(k4 * e3 + k12 * e4);
        r[3] = trunc_coef(k6 * d[0] - k10 * d[3] - k14 * d[1] - k2 * d[2]);
        r[4] = trunc_coef((e1 - e2) * 16);
        r[5] = trunc_coef(k10 * d[0] + k6 * d[3] - k2 * d[1] + k14 * d[2]);
        r[6] = trunc_coef(k12 * e3 - k4 * e4);
        r[7] = trunc_coef(k14 * d[0] - k2 * d[3] + k6 * d[2] - k10 * d[1]);
        return r;
    endfunction

    initial fail_count = 0;

    // history clears with the DUT registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_depth; i++) begin
                hist_x[i] <= '0;
            end
            hist_f <= '0;
            hist_v <= '0;
        end else begin
            hist_x[0] <= x_in;
            for (int i = 1; i < pipe_depth; i++) begin
                hist_x[i] <= hist_x[i-1];
            end
            hist_f <= {hist_f[pipe_depth-2:0], block_flag};
            hist_v <= {hist_v[pipe_depth-2:0], 1'b1};
        end
    end

    always_comb begin
        exp_valid = hist_v[pipe_depth-1];
        exp_coef  = exp_valid ? even_model(hist_x[pipe_depth-1], hist_f[pipe_depth-1]) : '0;
    end

    // nothing has emerged yet, output must read zero
    a_reset_zero: assert property (@(posedge clk) !exp_valid |-> x_out == '0)
        else begin
            fail_count++;
            $error("Fail reset_zero expected 0 actual %h", $sampled(x_out));
        end

    a_dc: assert property (@(posedge clk) exp_valid |-> x_out[0] == exp_coef[0])
        else begin
            fail_count++;
            $error("Fail dc expected %0d actual %0d", $sampled(exp_coef[0]), $sampled(x_out[0]));
        end

    // X4, X8, X12 from the second rank
    a_x4_x8_x12: assert property (@(posedge clk)
        exp_valid |-> {x_out[2], x_out[4], x_out[6]} == {exp_coef[2], exp_coef[4], exp_coef[6]})
        else begin
            fail_count++;
            $error("Fail x4_x8_x12 expected %h actual %h",
                   $sampled({exp_coef[2], exp_coef[4], exp_coef[6]}),
                   $sampled({x_out[2], x_out[4], x_out[6]}));
        end

    // rotations on d0..d3
    a_x2_x6_x10_x14: assert property (@(posedge clk)
        exp_valid |-> {x_out[1], x_out[3], x_out[5], x_out[7]}
                      == {exp_coef[1], exp_coef[3], exp_coef[5], exp_coef[7]})
        else begin
            fail_count++;
            $error("Fail x2_x6_x10_x14 expected %h actual %h",
                   $sampled({exp_coef[1], exp_coef[3], exp_coef[5], exp_coef[7]}),
                   $sampled({x_out[1], x_out[3], x_out[5], x_out[7]}));
        end

endmodule

bind dct_col_even dct_col_even_assert #(
    .trunc_lsb (trunc_lsb)
) dct_col_even_assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .x_in       (x_in),
    .block_flag (block_flag),
    .x_out      (x_out)
);

// ==== dv/dct_col_even_tb.sv ====
// stimulus only; the bound assertion module does all checking and counts its failures
`timescale 1ns/1ps

module dct_col_even_tb;

    import dct_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    // cycles per test
    localparam int const_cycles  = 16;
    localparam int random_cycles = 300;
    localparam int corner_cycles = 60;
    localparam int drain_cycles  = pipe_depth + 2;
    localparam int total_cycles  = reset_cycles + pipe_depth + const_cycles
                                 + random_cycles + corner_cycles + drain_cycles;
    // half again over the planned run
    localparam longint watchdog_ns = longint'(total_cycles) * clk_period * 3 / 2;

    logic           clk;
    logic           rst_n;
    sample_vec_t    x_in;
    logic           block_flag;
    even_coef_vec_t x_out;

    int timeout_count;

    // constant levels, the two extremes saturate the plain dc shift
    int const_vals [8] = '{1023, -1024, 0, 1, -1, 100, 511, -700};

    dct_col_even dct_col_even_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .x_in       (x_in),
        .block_flag (block_flag),
        .x_out      (x_out)
    );

    // apply one vector shortly after the rising edge
    task automatic drive(input sample_vec_t vec, input logic flag);
        @(posedge clk);
        #2;
        x_in = vec;
        block_flag = flag;
    endtask

    function automatic sample_vec_t const_vector(input int v);
        sample_vec_t r;
        for (int i = 0; i < n_points; i++) begin
            r[i] = sample_t'(v);
        end
        return r;
    endfunction

    function automatic sample_vec_t random_vector();
        sample_vec_t r;
        for (int i = 0; i < n_points; i++) begin
            r[i] = sample_t'($urandom);
        end
        return r;
    endfunction

    // every sample at full scale, pushes the truncation into wrap
    function automatic sample_vec_t corner_vector();
        sample_vec_t r;
        for (int i = 0; i < n_points; i++) begin
            r[i] = ($urandom % 2 == 1) ? sample_t'(1023) : sample_t'(-1024);
        end
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        timeout_count++;
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("errors: %0d assertion failures, %0d timeouts",
                 dct_col_even_i.dct_col_even_assert_i.fail_count, timeout_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(39));
        rst_n = 1'b0;
        // live data during reset, every stage register must still read zero
        x_in = random_vector();
        block_flag = 1'b1;
        timeout_count = 0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // fresh vectors while the pipeline fills, x_out stays zero until the first emerges
        repeat (pipe_depth) drive(random_vector(), $urandom % 2 == 1);
        // each level with both dc scalings
        foreach (const_vals[i]) begin
            drive(const_vector(const_vals[i]), 1'b1);
            drive(const_vector(const_vals[i]), 1'b0);
        end
        // new vector and flag every cycle, three in flight
        repeat (random_cycles) drive(random_vector(), $urandom % 2 == 1);
        repeat (corner_cycles) drive(corner_vector(), $urandom % 2 == 1);
        // let the last vectors reach x_out and be checked
        repeat (drain_cycles) drive('0, 1'b0);
        @(posedge clk);
        $display("errors: %0d assertion failures, %0d timeouts",
                 dct_col_even_i.dct_col_even_assert_i.fail_count, timeout_count);
        if (dct_col_even_i.dct_col_even_assert_i.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== dct_col_even.f ====
source/dct_pkg.sv
source/dct_fold_stage.sv
source/dct_even_butterfly.sv
source/dct_coef_stage.sv
source/dct_col_even.sv
dv/dct_col_even_assert.sv
dv/dct_col_even_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the even DCT testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dct_col_even_tb \
    -f dct_col_even.f -o dct_col_even_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/dct_col_even_sim +verilator+error+limit+100000 > "$log" 2>&1
status=$?

if grep -q "Simulation FAILED" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi
if [ $status -ne 0 ] || ! grep -q "Simulation PASSED" "$log"; then
    echo "simulation did not complete, see $log"
    exit 1
fi
echo "simulation passed"
exit 0
